// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pcm_core
FLIST     ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
pcm_pkg.sv
pcm_clkgen.sv
pcm_regs.sv
pcm_channel.sv
pcm_mixer.sv
pcm_core.sv
tb_pcm_core.sv

// File: pcm_channel.sv
/*
 * one pcm playback channel
 * prescaler counter with three overflow modes
 * rom address stepping, end marker with loop or stop
 * 7-bit unsigned to signed sample conversion
 */

`timescale 1ns/1ns

module pcm_channel import pcm_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      tick,
    // controls from the register file
    input  rom_addr_t start,
    input  pres_t     reload,
    input  presel_t   mode,
    input  logic      loop,
    input  logic      load,
    input  logic      play,
    // sample rom port
    output rom_addr_t rom_addr,
    output logic      rom_cs,
    input  byte_t     rom_dout,
    input  logic      rom_ok,
    // channel output
    output sample_t   snd
);

    chan_state_t state;
    pres_t       cnt;
    pres_t       cnt_next;
    rom_addr_t   addr_next;
    logic        over;
    logic        play_l;
    sample_t     conv;

    // overflow point depends on the prescaler mode
    always_comb begin
        if (mode[0]) begin
            over = &cnt[7:0];
        end else if (mode[1]) begin
            over = &cnt[11:8];
        end else begin
            over = &cnt;
        end
    end

    // split mode counts the low byte and top nibble apart
    always_comb begin
        if (mode[1] && !mode[0]) begin
            cnt_next[7:0]  = cnt[7:0] + 8'd1;
            cnt_next[11:8] = cnt[11:8] + 4'd1;
        end else begin
            cnt_next = cnt + pres_t'(1);
        end
    end

    // split mode steps every nibble with its own wrap
    always_comb begin
        if (mode[1] && !mode[0]) begin
            addr_next[3:0]   = rom_addr[3:0] + 4'd1;
            addr_next[7:4]   = rom_addr[7:4] + 4'd1;
            addr_next[11:8]  = rom_addr[11:8] + 4'd1;
            addr_next[16:12] = rom_addr[16:12] + 5'd1;
        end else begin
            addr_next = rom_addr + rom_addr_t'(1);
        end
    end

    // low seven bits around the midpoint
    assign conv   = $signed({1'b0, rom_dout[6:0]} - SAMPLE_OFFSET);
    assign rom_cs = (state == CH_PLAY);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= CH_IDLE;
            cnt      <= '0;
            rom_addr <= '0;
            play_l   <= 1'b0;
            snd      <= '0;
        end else begin
            play_l <= play;
            if (tick) begin
                if (over) begin
                    cnt <= reload;
                    if (state == CH_PLAY) begin
                        // byte at the current address plays now
                        rom_addr <= addr_next;
                        snd      <= conv;
                        // bit 7 marks the last byte
                        if (rom_dout[7]) begin
                            if (loop) begin
                                rom_addr <= start;
                            end else begin
                                state <= CH_IDLE;
                            end
                        end
                    end
                end else begin
                    cnt <= cnt_next;
                end
            end
            // start on the rising edge of play
            if (play && !play_l) begin
                state    <= CH_PLAY;
                rom_addr <= start;
            end
            if (load) begin
                cnt <= reload;
            end
            // silent while idle
            if (state == CH_IDLE) begin
                snd <= '0;
            end
        end
    end

    // an idle channel outputs silence on the next cycle
    assert property (@(posedge clk) disable iff (rst) !rom_cs |=> (snd == '0));

    // rom data must be valid whenever a byte is taken
    assert property (@(posedge clk) disable iff (rst) (tick && over && rom_cs) |-> rom_ok);

endmodule

// File: pcm_clkgen.sv
/*
 * clock enable generator
 * E and Q enables of the 6809 host, a quarter of the cen rate each
 * channel tick at one eighth of the cen rate
 */

`timescale 1ns/1ns

module pcm_clkgen (
    input  logic clk,
    input  logic rst,
    input  logic cen,
    output logic cen_e,
    output logic cen_q,
    output logic tick
);

    // cen pulse counter, modulo 4
    logic [1:0] cen_cnt;
    // toggles with every cen_q
    logic       div2;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen_cnt <= '0;
            div2    <= 1'b0;
            cen_e   <= 1'b0;
            cen_q   <= 1'b0;
            tick    <= 1'b0;
        end else begin
            if (cen) begin
                cen_cnt <= cen_cnt + 2'd1;
            end
            // q on count 1, e on count 3, half a cpu cycle apart
            cen_q <= cen && (cen_cnt == 2'd1);
            cen_e <= cen && (cen_cnt == 2'd3);
            // every second q slot drives the channels
            tick  <= cen && (cen_cnt == 2'd1) && div2;
            if (cen_q) begin
                div2 <= ~div2;
            end
        end
    end

    // e and q are taken from different counter phases
    assert property (@(posedge clk) disable iff (rst) !(cen_e && cen_q));

endmodule

// File: pcm_core.sv
/*
 * top level of the two-channel pcm sample player
 * clock enable generator, register file, two channels, mixer
 */

`timescale 1ns/1ns

module pcm_core import pcm_pkg::*; #(
    parameter bit GAIN_A_HIGH = 1'b1,
    parameter bit INVERT_A0   = 1'b0
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      cen,
    // cpu port
    input  reg_addr_t addr,
    input  logic      dacs,
    input  logic      wr_n,
    input  byte_t     din,
    // 6809 clock enables
    output logic      cen_e,
    output logic      cen_q,
    // channel A sample rom
    output rom_addr_t roma_addr,
    output logic      roma_cs,
    input  byte_t     roma_dout,
    input  logic      roma_ok,
    // channel B sample rom
    output rom_addr_t romb_addr,
    output logic      romb_cs,
    input  byte_t     romb_dout,
    input  logic      romb_ok,
    // audio
    output sample_t   snda,
    output sample_t   sndb,
    output mix_t      snd
);

    logic      tick;
    rom_addr_t start_a, start_b;
    pres_t     reload_a, reload_b;
    presel_t   mode_a, mode_b;
    logic      loop_a, loop_b;
    logic      load_a, load_b;
    logic      play_a, play_b;
    gain_t     gain_a, gain_b;

    pcm_clkgen u_clkgen (
        .clk   (clk),
        .rst   (rst),
        .cen   (cen),
        .cen_e (cen_e),
        .cen_q (cen_q),
        .tick  (tick)
    );

    pcm_regs #(
        .GAIN_A_HIGH (GAIN_A_HIGH),
        .INVERT_A0   (INVERT_A0)
    ) u_regs (
        .clk      (clk),
        .rst      (rst),
        .addr     (addr),
        .dacs     (dacs),
        .wr_n     (wr_n),
        .din      (din),
        .start_a  (start_a),
        .reload_a (reload_a),
        .mode_a   (mode_a),
        .loop_a   (loop_a),
        .load_a   (load_a),
        .play_a   (play_a),
        .start_b  (start_b),
        .reload_b (reload_b),
        .mode_b   (mode_b),
        .loop_b   (loop_b),
        .load_b   (load_b),
        .play_b   (play_b),
        .gain_a   (gain_a),
        .gain_b   (gain_b)
    );

    pcm_channel u_cha (
        .clk      (clk),
        .rst      (rst),
        .tick     (tick),
        .start    (start_a),
        .reload   (reload_a),
        .mode     (mode_a),
        .loop     (loop_a),
        .load     (load_a),
        .play     (play_a),
        .rom_addr (roma_addr),
        .rom_cs   (roma_cs),
        .rom_dout (roma_dout),
        .rom_ok   (roma_ok),
        .snd      (snda)
    );

    pcm_channel u_chb (
        .clk      (clk),
        .rst      (rst),
        .tick     (tick),
        .start    (start_b),
        .reload   (reload_b),
        .mode     (mode_b),
        .loop     (loop_b),
        .load     (load_b),
        .play     (play_b),
        .rom_addr (romb_addr),
        .rom_cs   (romb_cs),
        .rom_dout (romb_dout),
        .rom_ok   (romb_ok),
        .snd      (sndb)
    );

    pcm_mixer u_mixer (
        .clk    (clk),
        .rst    (rst),
        .snda   (snda),
        .sndb   (sndb),
        .gain_a (gain_a),
        .gain_b (gain_b),
        .snd    (snd)
    );

endmodule

// File: pcm_mixer.sv
/*
 * two-stage channel mixer
 * per-channel gain multiply, then the sum
 */

`timescale 1ns/1ns

module pcm_mixer import pcm_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  sample_t snda,
    input  sample_t sndb,
    input  gain_t   gain_a,
    input  gain_t   gain_b,
    output mix_t    snd
);

    // scaled channels up to 64 * 15 in magnitude
    mix_t amp_a;
    mix_t amp_b;
    // gains as positive signed operands
    logic signed [4:0] gain_a_s;
    logic signed [4:0] gain_b_s;

    assign gain_a_s = $signed({1'b0, gain_a});
    assign gain_b_s = $signed({1'b0, gain_b});

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            amp_a <= '0;
            amp_b <= '0;
            snd   <= '0;
        end else begin
            // stage 1 scales each channel
            amp_a <= mix_t'(snda * gain_a_s);
            amp_b <= mix_t'(sndb * gain_b_s);
            // stage 2 sum stays within 1920 and needs no saturation
            snd   <= amp_a + amp_b;
        end
    end

endmodule

// File: pcm_pkg.sv
/*
 * shared types for the two-channel pcm sample player
 * vector typedefs for addresses, data, prescaler, gains and audio
 * channel state enum
 * sample offset constant
 */

package pcm_pkg;

    // sample rom byte address, 128 kbyte per channel
    typedef logic [16:0] rom_addr_t;

    // register or rom data byte
    typedef logic [7:0] byte_t;

    // register index, 0 to 13 in use
    typedef logic [3:0] reg_addr_t;

    // prescaler count and reload value
    typedef logic [11:0] pres_t;

    // prescaler mode
    // bit 0 set: 8-bit count only
    // else bit 1 set: split nibble count, address steps per nibble
    // else: full 12-bit count
    typedef logic [1:0] presel_t;

    // unsigned channel gain
    typedef logic [3:0] gain_t;

    // channel output, -64 to +63
    typedef logic signed [7:0] sample_t;

    // mixed output of both channels
    typedef logic signed [11:0] mix_t;

    // channel fsm
    typedef enum logic {
        CH_IDLE = 1'b0,
        CH_PLAY = 1'b1
    } chan_state_t;

    // midpoint of the 7-bit unsigned sample
    localparam byte_t SAMPLE_OFFSET = 8'h40;

endpackage

// File: pcm_regs.sv
/*
 * cpu register file of the sample player
 * write decode of the 14 byte registers
 * field decode for both channels and the gain nibbles
 * load and play pulses
 */

`timescale 1ns/1ns

module pcm_regs import pcm_pkg::*; #(
    parameter bit GAIN_A_HIGH = 1'b1,
    parameter bit INVERT_A0   = 1'b0
) (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t addr,
    input  logic      dacs,
    input  logic      wr_n,
    input  byte_t     din,
    // channel A controls
    output rom_addr_t start_a,
    output pres_t     reload_a,
    output presel_t   mode_a,
    output logic      loop_a,
    output logic      load_a,
    output logic      play_a,
    // channel B controls
    output rom_addr_t start_b,
    output pres_t     reload_b,
    output presel_t   mode_b,
    output logic      loop_b,
    output logic      load_b,
    output logic      play_b,
    // mixer gains
    output gain_t     gain_a,
    output gain_t     gain_b
);

    localparam int NUM_REGS = 14;

    byte_t     mmr [NUM_REGS];
    reg_addr_t addrj;
    logic      wr;

    // the original part decodes with A0 inverted
    assign addrj = INVERT_A0 ? (addr ^ reg_addr_t'(1)) : addr;
    // indices 14 and 15 are not backed by a register
    assign wr    = dacs && !wr_n && (addrj < reg_addr_t'(NUM_REGS));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                mmr[i] <= '0;
            end
            load_a <= 1'b0;
            load_b <= 1'b0;
            play_a <= 1'b0;
            play_b <= 1'b0;
        end else begin
            if (wr) begin
                mmr[addrj] <= din;
            end
            // prescaler reload follows a write to either reload byte
            load_a <= wr && (addrj == 4'd0 || addrj == 4'd1);
            load_b <= wr && (addrj == 4'd6 || addrj == 4'd7);
            // play needs only the chip select, reads trigger too
            play_a <= dacs && (addrj == 4'd5);
            play_b <= dacs && (addrj == 4'd11);
        end
    end

    // channel A fields, registers 0 to 4
    assign reload_a = {mmr[1][3:0], mmr[0]};
    assign mode_a   = mmr[1][5:4];
    assign start_a  = {mmr[4][0], mmr[3], mmr[2]};

    // channel B fields, registers 6 to 10
    assign reload_b = {mmr[7][3:0], mmr[6]};
    assign mode_b   = mmr[7][5:4];
    assign start_b  = {mmr[10][0], mmr[9], mmr[8]};

    // register 13 holds both loop flags
    assign loop_a = mmr[13][0];
    assign loop_b = mmr[13][1];

    // register 12 nibble order set per board
    assign gain_a = GAIN_A_HIGH ? mmr[12][7:4] : mmr[12][3:0];
    assign gain_b = GAIN_A_HIGH ? mmr[12][3:0] : mmr[12][7:4];

    // play pulses come one cycle after the chip select
    assert property (@(posedge clk) disable iff (rst)
        (play_a || play_b) |-> $past(dacs));

endmodule

// File: tb_pcm_core.sv
/*
 * testbench for the two-channel pcm sample player
 * clock, reset, lfsr driven cen, cpu register writes
 * two sample rom models with end markers
 * reference functions, compare tasks and a cycle timeout
 */

`timescale 1ns/1ns

module tb_pcm_core import pcm_pkg::*; ();

    localparam bit GAIN_A_HIGH = 1'b1;
    // samples checked in tests 2 to 4
    localparam int SAMPLE_COUNT = 7 + 12 + 7;
    // longest reload used gives two ticks per sample
    localparam int PRES_PERIOD  = 2;
    // one tick per 8 cen pulses
    localparam int CEN_PER_TICK = 8;
    // fixed windows of tests 1 and 5 plus register writes
    localparam int FIXED_CYCLES = 800 + 2 * 520 + 200;
    // cen comes about every second clock, doubled for margin
    localparam int MAX_CYCLES   = SAMPLE_COUNT * PRES_PERIOD * CEN_PER_TICK * 4
                                  + FIXED_CYCLES + 1000;

    logic      clk;
    logic      rst;
    logic      cen;
    reg_addr_t addr;
    logic      dacs;
    logic      wr_n;
    byte_t     din;
    logic      cen_e;
    logic      cen_q;
    rom_addr_t roma_addr;
    logic      roma_cs;
    byte_t     roma_dout;
    logic      roma_ok;
    rom_addr_t romb_addr;
    logic      romb_cs;
    byte_t     romb_dout;
    logic      romb_ok;
    sample_t   snda;
    sample_t   sndb;
    mix_t      snd;

    // rom models of 64 bytes indexed by the low address bits
    byte_t rom_a [64];
    byte_t rom_b [64];

    int errors;
    int checks;
    int tests_passed;
    int tests_failed;
    int cycles;
    // clock enable counters
    logic count_en;
    int   n_cen;
    int   n_q;
    int   n_e;
    int   n_both;

    pcm_core #(
        .GAIN_A_HIGH (GAIN_A_HIGH),
        .INVERT_A0   (1'b0)
    ) u_pcm_core (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .addr      (addr),
        .dacs      (dacs),
        .wr_n      (wr_n),
        .din       (din),
        .cen_e     (cen_e),
        .cen_q     (cen_q),
        .roma_addr (roma_addr),
        .roma_cs   (roma_cs),
        .roma_dout (roma_dout),
        .roma_ok   (roma_ok),
        .romb_addr (romb_addr),
        .romb_cs   (romb_cs),
        .romb_dout (romb_dout),
        .romb_ok   (romb_ok),
        .snda      (snda),
        .sndb      (sndb),
        .snd       (snd)
    );

    // rom answers in the same cycle and is always valid
    assign roma_dout = rom_a[roma_addr[5:0]];
    assign romb_dout = rom_b[romb_addr[5:0]];
    assign roma_ok   = 1'b1;
    assign romb_ok   = 1'b1;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // random cen with one lfsr step per bit
    initial begin
        logic [31:0] lfsr;
        lfsr = 32'he685;
        cen  = 1'b0;
        forever begin
            @(posedge clk);
            #5;
            lfsr = lfsr_step(lfsr);
            cen  = lfsr[0];
        end
    end

    // outputs sampled mid cycle
    always @(negedge clk) begin
        if (count_en) begin
            n_cen  <= n_cen + int'(cen);
            n_q    <= n_q + int'(cen_q);
            n_e    <= n_e + int'(cen_e);
            n_both <= n_both + int'(cen_q && cen_e);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout, no result after %0d cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

    // 7-bit unsigned byte around the midpoint 64
    function automatic sample_t ref_sample(input byte_t b);
        int v;
        v = int'(b[6:0]) - 64;
        return sample_t'(v);
    endfunction

    function automatic mix_t ref_mix(input sample_t a, input sample_t b,
                                     input gain_t ga, input gain_t gb);
        int s;
        s = int'(a) * int'(ga) + int'(b) * int'(gb);
        return mix_t'(s);
    endfunction

    // split mode counts each nibble and the 5-bit top field on their own
    function automatic rom_addr_t ref_next_addr(input rom_addr_t a, input logic split);
        rom_addr_t r;
        int        field;
        int        mask;
        r = '0;
        if (split) begin
            for (int n = 0; n < 4; n++) begin
                mask  = (n == 3) ? 31 : 15;
                field = ((int'(a) >> (4 * n)) + 1) & mask;
                r     = r | rom_addr_t'(field << (4 * n));
            end
        end else begin
            r = rom_addr_t'(int'(a) + 1);
        end
        return r;
    endfunction

    task automatic check_sample(input string name, input sample_t got, input sample_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_mix(input string name, input mix_t got, input mix_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input rom_addr_t got, input rom_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp, input int tol);
        checks++;
        if (got > exp + tol || got < exp - tol) begin
            errors++;
            $display("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic write_reg(input reg_addr_t a, input byte_t d);
        @(posedge clk);
        #5;
        addr = a;
        din  = d;
        dacs = 1'b1;
        wr_n = 1'b0;
        @(posedge clk);
        #5;
        dacs = 1'b0;
        wr_n = 1'b1;
    endtask

    task automatic wait_snda_change(input sample_t old);
        do @(negedge clk); while (snda == old);
    endtask

    task automatic wait_sndb_change(input sample_t old);
        do @(negedge clk); while (sndb == old);
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        if (errors == err_before) begin
            tests_passed++;
            $display("test %0d %s: pass", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL, %0d errors", num, name, errors - err_before);
        end
    endtask

    // q and e each at a quarter of the cen rate and never together
    task automatic test_clock_enables();
        count_en = 1'b1;
        repeat (800) @(posedge clk);
        count_en = 1'b0;
        @(negedge clk);
        check_count("cen_q pulses", n_q, n_cen / 4, 1);
        check_count("cen_e pulses", n_e, n_cen / 4, 1);
        check_count("cen_q minus cen_e", n_q - n_e, 0, 1);
        check_count("cen_q and cen_e overlap", n_both, 0, 0);
    endtask

    // channel A in full mode with the marker at byte 5
    task automatic test_one_shot();
        sample_t   prev;
        rom_addr_t exp_addr;
        write_reg(4'd0, 8'hfe);
        write_reg(4'd1, 8'h0f);
        write_reg(4'd2, 8'h00);
        write_reg(4'd3, 8'h00);
        write_reg(4'd4, 8'h00);
        write_reg(4'd13, 8'h00);
        write_reg(4'd5, 8'h00);
        prev     = '0;
        exp_addr = '0;
        for (int k = 0; k < 6; k++) begin
            wait_snda_change(prev);
            check_sample("snda", snda, ref_sample(rom_a[k]));
            exp_addr = ref_next_addr(exp_addr, 1'b0);
            check_addr("roma_addr", roma_addr, exp_addr);
            prev = snda;
        end
        check_flag("roma_cs", roma_cs, 1'b0);
        wait_snda_change(prev);
        check_sample("snda", snda, '0);
        check_flag("roma_cs", roma_cs, 1'b0);
    endtask

    // channel B loops over bytes 0x20 to 0x23
    task automatic test_loop();
        sample_t   prev;
        rom_addr_t base;
        rom_addr_t exp_addr;
        write_reg(4'd6, 8'hfe);
        write_reg(4'd7, 8'h0f);
        write_reg(4'd8, 8'h20);
        write_reg(4'd9, 8'h00);
        write_reg(4'd10, 8'h00);
        write_reg(4'd13, 8'h02);
        write_reg(4'd11, 8'h00);
        base = 17'h00020;
        prev = '0;
        for (int pass = 0; pass < 3; pass++) begin
            for (int k = 0; k < 4; k++) begin
                wait_sndb_change(prev);
                check_sample("sndb", sndb, ref_sample(rom_b[32 + k]));
                // the marker byte sends the address back to the start
                if (rom_b[32 + k][7]) begin
                    exp_addr = base;
                end else begin
                    exp_addr = ref_next_addr(base + rom_addr_t'(k), 1'b0);
                end
                check_addr("romb_addr", romb_addr, exp_addr);
                check_flag("romb_cs", romb_cs, 1'b1);
                prev = sndb;
            end
        end
    endtask

    // channel A in split mode never reaches the marker
    task automatic test_split_addr();
        rom_addr_t old;
        write_reg(4'd0, 8'h00);
        write_reg(4'd1, 8'h2e);
        write_reg(4'd2, 8'h0e);
        write_reg(4'd5, 8'h00);
        repeat (2) @(negedge clk);
        check_addr("roma_addr", roma_addr, 17'h0000e);
        old = roma_addr;
        for (int k = 0; k < 6; k++) begin
            do @(negedge clk); while (roma_addr == old);
            check_addr("roma_addr", roma_addr, ref_next_addr(old, 1'b1));
            old = roma_addr;
        end
    endtask

    // snd checked once both samples held for 3 cycles
    task automatic mix_window(input byte_t g);
        gain_t   ga;
        gain_t   gb;
        sample_t last_a;
        sample_t last_b;
        int      stable;
        int      n_checked;
        ga = GAIN_A_HIGH ? g[7:4] : g[3:0];
        gb = GAIN_A_HIGH ? g[3:0] : g[7:4];
        write_reg(4'd12, g);
        repeat (4) @(negedge clk);
        last_a    = snda;
        last_b    = sndb;
        stable    = 0;
        n_checked = 0;
        repeat (500) begin
            @(negedge clk);
            if (snda == last_a && sndb == last_b) begin
                stable++;
            end else begin
                stable = 0;
            end
            last_a = snda;
            last_b = sndb;
            if (stable >= 3) begin
                check_mix("snd", snd, ref_mix(snda, sndb, ga, gb));
                n_checked++;
            end
        end
        if (n_checked == 0) begin
            errors++;
            $display("mix window with gains 0x%h never saw stable channel outputs", g);
        end
    endtask

    initial begin
        int e0;
        errors       = 0;
        checks       = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycles       = 0;
        count_en     = 1'b0;
        n_cen        = 0;
        n_q          = 0;
        n_e          = 0;
        n_both       = 0;
        addr         = '0;
        dacs         = 1'b0;
        wr_n         = 1'b1;
        din          = '0;
        // alternate low and high values with the marker in bit 7
        for (int i = 0; i < 64; i++) begin
            rom_a[i] = i[0] ? byte_t'(8'h08 + (i >> 1)) : byte_t'(8'h48 + (i >> 1));
            rom_b[i] = i[0] ? byte_t'(8'h4c + (i >> 1)) : byte_t'(8'h0c + (i >> 1));
        end
        rom_a[5]  = rom_a[5] | 8'h80;
        rom_b[35] = rom_b[35] | 8'h80;
        rst = 1'b1;
        repeat (10) @(posedge clk);
        #5;
        rst = 1'b0;

        e0 = errors;
        test_clock_enables();
        report_test(1, "clock enables", e0);
        e0 = errors;
        test_one_shot();
        report_test(2, "one-shot playback", e0);
        e0 = errors;
        test_loop();
        report_test(3, "looping", e0);
        e0 = errors;
        test_split_addr();
        report_test(4, "address stepping", e0);
        e0 = errors;
        mix_window(8'h3c);
        mix_window(8'hc3);
        report_test(5, "mixing", e0);

        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
